// ==== cam_pkg.sv ====
`default_nettype none

package cam_pkg;

   // bus widths shared by the camera pipeline
   localparam int PIX_W  = 16;
   localparam int CHAN_W = 8;

   // rgb565, red in the top five bits
   typedef logic [PIX_W-1:0] pixel_t;
   // colour channel widened to 8 bits
   typedef logic [CHAN_W-1:0] chan_t;

   // what gets written into the frame buffer
   typedef enum logic {
      VIEW_CAMERA,
      VIEW_MASK
   } view_e;

   // centroid divider phases, x quotient first
   typedef enum logic [1:0] {
      DIV_IDLE,
      DIV_X,
      DIV_Y
   } div_state_e;

   // inclusive pink window on cr
   localparam chan_t CR_LOW  = 8'd160;
   localparam chan_t CR_HIGH = 8'd240;

   // crosshair and mask hit colour
   localparam pixel_t PIXEL_WHITE = '1;

endpackage

`default_nettype wire

// ==== pixel_reconstruct.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_reconstruct #(
   parameter int  FRAME_W = 320,
   parameter int  FRAME_H = 180,
   localparam int HW      = $clog2(FRAME_W),
   localparam int VW      = $clog2(FRAME_H)
) (
   input wire              clk_camera,
   input wire              sys_rst_camera,
   input wire              cam_pclk_i,
   input wire              cam_hs_i,
   input wire              cam_vs_i,
   input wire [7:0]        cam_data_i,
   output logic            pix_valid_o,
   output cam_pkg::pixel_t pix_o,
   output logic [HW-1:0]   hcount_o,
   output logic [VW-1:0]   vcount_o
);

   // [0] first sync stage, [1] synced value, [2] previous synced value
   logic [2:0]    pclk_sr;
   logic [2:0]    hs_sr;
   logic [2:0]    vs_sr;
   // data delayed two stages to line up with pclk_sr[1]
   logic [7:0]    data_s0;
   logic [7:0]    data_s1;
   logic          pclk_rise;
   logic          hs_fall;
   logic          vs_rise;
   logic          take_byte;
   // high when the next byte is the low half
   logic          low_phase;
   logic [7:0]    hi_byte;
   logic [HW-1:0] col;
   logic [VW-1:0] row;

   assign pclk_rise = pclk_sr[1] & ~pclk_sr[2];
   assign hs_fall   = ~hs_sr[1] & hs_sr[2];
   assign vs_rise   = vs_sr[1] & ~vs_sr[2];
   // bytes only count inside an active line
   assign take_byte = pclk_rise & hs_sr[1];

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_sr     <= '0;
         hs_sr       <= '0;
         vs_sr       <= '0;
         low_phase   <= 1'b0;
         col         <= '0;
         row         <= '0;
         pix_valid_o <= 1'b0;
      end else begin
         pclk_sr     <= {pclk_sr[1:0], cam_pclk_i};
         hs_sr       <= {hs_sr[1:0], cam_hs_i};
         vs_sr       <= {vs_sr[1:0], cam_vs_i};
         pix_valid_o <= 1'b0;
         if (vs_rise) begin
            // start of frame
            low_phase <= 1'b0;
            col       <= '0;
            row       <= '0;
         end else if (hs_fall) begin
            // end of line, a stray half pixel is dropped
            low_phase <= 1'b0;
            col       <= '0;
            row       <= row + 1'b1;
         end else if (take_byte) begin
            low_phase <= ~low_phase;
            if (low_phase) begin
               pix_valid_o <= 1'b1;
               col         <= col + 1'b1;
            end
         end
      end
   end

   // pixel fields, qualified by pix_valid_o
   always_ff @(posedge clk_camera) begin
      data_s0 <= cam_data_i;
      data_s1 <= data_s0;
      if (take_byte) begin
         if (low_phase) begin
            pix_o    <= {hi_byte, data_s1};
            hcount_o <= col;
            vcount_o <= row;
         end else begin
            hi_byte <= data_s1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== pink_threshold.sv ====
`timescale 1ns/1ns
`default_nettype none

module pink_threshold #(
   parameter int HCOUNT_W = 9,
   parameter int VCOUNT_W = 8
) (
   input wire                  clk_camera,
   input wire                  sys_rst_camera,
   input wire                  pix_valid_i,
   input wire cam_pkg::pixel_t pix_i,
   input wire [HCOUNT_W-1:0]   hcount_i,
   input wire [VCOUNT_W-1:0]   vcount_i,
   output logic                thr_valid_o,
   output logic                mask_o,
   output cam_pkg::pixel_t     pix_o,
   output logic [HCOUNT_W-1:0] hcount_o,
   output logic [VCOUNT_W-1:0] vcount_o
);

   cam_pkg::chan_t     red;
   cam_pkg::chan_t     green;
   cam_pkg::chan_t     blue;
   cam_pkg::chan_t     cr;
   logic signed [17:0] cr_sum;
   logic signed [17:0] cr_full;
   logic               in_range;

   always_comb begin
      // widen rgb565 fields by shifting left
      red   = {pix_i[15:11], 3'b000};
      green = {pix_i[10:5], 2'b00};
      blue  = {pix_i[4:0], 3'b000};
      // 112 r - 94 g - 18 b, can go negative
      cr_sum = 18'sd112 * $signed({10'd0, red})
             - 18'sd94 * $signed({10'd0, green})
             - 18'sd18 * $signed({10'd0, blue});
      // arithmetic shift floors toward minus infinity
      cr_full  = 18'sd128 + (cr_sum >>> 8);
      // result always lies in 16..239
      cr       = cr_full[7:0];
      in_range = (cr >= cam_pkg::CR_LOW) && (cr <= cam_pkg::CR_HIGH);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         thr_valid_o <= 1'b0;
      end else begin
         thr_valid_o <= pix_valid_i;
      end
   end

   // one stage delay for the pixel fields
   always_ff @(posedge clk_camera) begin
      if (pix_valid_i) begin
         mask_o   <= in_range;
         pix_o    <= pix_i;
         hcount_o <= hcount_i;
         vcount_o <= vcount_i;
      end
   end

endmodule

`default_nettype wire

// ==== centroid_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module centroid_tracker #(
   parameter int  FRAME_W = 320,
   parameter int  FRAME_H = 180,
   localparam int HW      = $clog2(FRAME_W),
   localparam int VW      = $clog2(FRAME_H)
) (
   input wire            clk_camera,
   input wire            sys_rst_camera,
   input wire            thr_valid_i,
   input wire            mask_i,
   input wire [HW-1:0]   hcount_i,
   input wire [VW-1:0]   vcount_i,
   output logic [HW-1:0] com_x_o,
   output logic [VW-1:0] com_y_o,
   output logic          com_valid_o,
   output logic          has_com_o
);

   // pink pixel count and coordinate sums
   localparam int CNT_W  = $clog2(FRAME_W * FRAME_H + 1);
   localparam int SX_W   = HW + CNT_W;
   localparam int SY_W   = VW + CNT_W;
   // one divider wide enough for either sum
   localparam int DIV_W  = (SX_W > SY_W) ? SX_W : SY_W;
   localparam int STEP_W = $clog2(DIV_W);

   cam_pkg::div_state_e state;
   logic [SX_W-1:0]     sum_x;
   logic [SY_W-1:0]     sum_y;
   logic [CNT_W-1:0]    count;
   logic [SX_W-1:0]     sum_x_nx;
   logic [SY_W-1:0]     sum_y_nx;
   logic [CNT_W-1:0]    count_nx;
   logic                frame_end;
   logic                start;
   // divider datapath
   logic [SY_W-1:0]     y_hold;
   logic [CNT_W-1:0]    divisor;
   logic [CNT_W-1:0]    rem;
   logic [DIV_W-1:0]    quo;
   logic [STEP_W-1:0]   step;
   logic [CNT_W:0]      trial;
   logic                fits;
   logic [CNT_W-1:0]    rem_nx;
   logic [DIV_W-1:0]    quo_nx;
   logic                step_last;

   always_comb begin
      // current pixel folded in, so the last pixel of a frame counts
      sum_x_nx  = sum_x;
      sum_y_nx  = sum_y;
      count_nx  = count;
      if (thr_valid_i && mask_i) begin
         sum_x_nx = sum_x + SX_W'(hcount_i);
         sum_y_nx = sum_y + SY_W'(vcount_i);
         count_nx = count + 1'b1;
      end
      frame_end = thr_valid_i && (hcount_i == HW'(FRAME_W - 1))
                  && (vcount_i == VW'(FRAME_H - 1));
      // a frame ending while busy is simply not divided
      start     = frame_end && (count_nx != '0) && (state == cam_pkg::DIV_IDLE);
      // restoring step, dividend msb shifts into the remainder
      trial     = {rem, quo[DIV_W-1]};
      fits      = trial >= {1'b0, divisor};
      rem_nx    = fits ? CNT_W'(trial - {1'b0, divisor}) : trial[CNT_W-1:0];
      quo_nx    = {quo[DIV_W-2:0], fits};
      step_last = step == STEP_W'(DIV_W - 1);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state       <= cam_pkg::DIV_IDLE;
         sum_x       <= '0;
         sum_y       <= '0;
         count       <= '0;
         com_valid_o <= 1'b0;
         has_com_o   <= 1'b0;
      end else begin
         com_valid_o <= 1'b0;
         // accumulators restart every frame
         if (frame_end) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
         end else if (thr_valid_i) begin
            sum_x <= sum_x_nx;
            sum_y <= sum_y_nx;
            count <= count_nx;
         end
         if (start) begin
            state <= cam_pkg::DIV_X;
         end else if (step_last && state == cam_pkg::DIV_X) begin
            state <= cam_pkg::DIV_Y;
         end else if (step_last && state == cam_pkg::DIV_Y) begin
            state       <= cam_pkg::DIV_IDLE;
            com_valid_o <= 1'b1;
            has_com_o   <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (start) begin
         quo     <= DIV_W'(sum_x_nx);
         y_hold  <= sum_y_nx;
         divisor <= count_nx;
         rem     <= '0;
         step    <= '0;
      end else if (state != cam_pkg::DIV_IDLE) begin
         if (step_last) begin
            // x done, reload with the held y sum
            quo  <= DIV_W'(y_hold);
            rem  <= '0;
            step <= '0;
            if (state == cam_pkg::DIV_X) begin
               com_x_o <= quo_nx[HW-1:0];
            end else begin
               com_y_o <= quo_nx[VW-1:0];
            end
         end else begin
            quo  <= quo_nx;
            rem  <= rem_nx;
            step <= step + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== frame_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_writer #(
   parameter int  FRAME_W = 320,
   parameter int  FRAME_H = 180,
   localparam int HW      = $clog2(FRAME_W),
   localparam int VW      = $clog2(FRAME_H),
   localparam int AW      = $clog2(FRAME_W * FRAME_H)
) (
   input wire                  clk_camera,
   input wire                  sys_rst_camera,
   input wire                  thr_valid_i,
   input wire                  mask_i,
   input wire cam_pkg::pixel_t pix_i,
   input wire [HW-1:0]         hcount_i,
   input wire [VW-1:0]         vcount_i,
   input wire [HW-1:0]         com_x_i,
   input wire [VW-1:0]         com_y_i,
   input wire                  has_com_i,
   input var cam_pkg::view_e   view_i,
   output logic                wr_req_o,
   output logic [AW-1:0]       wr_addr_o,
   output cam_pkg::pixel_t     wr_data_o
);

   cam_pkg::pixel_t out_pix;
   logic            on_cross;

   always_comb begin
      // crosshair sits on the last known centre
      on_cross = has_com_i && ((vcount_i == com_y_i) || (hcount_i == com_x_i));
      if (on_cross) begin
         out_pix = cam_pkg::PIXEL_WHITE;
      end else if (view_i == cam_pkg::VIEW_MASK) begin
         out_pix = mask_i ? cam_pkg::PIXEL_WHITE : '0;
      end else begin
         out_pix = pix_i;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         wr_req_o <= 1'b0;
      end else begin
         wr_req_o <= thr_valid_i;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (thr_valid_i) begin
         // row major, FRAME_W pixels per line
         wr_addr_o <= AW'(vcount_i) * AW'(FRAME_W) + AW'(hcount_i);
         wr_data_o <= out_pix;
      end
   end

endmodule

`default_nettype wire

// ==== fb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module fb_arbiter #(
   parameter int  FRAME_W = 320,
   parameter int  FRAME_H = 180,
   localparam int AW      = $clog2(FRAME_W * FRAME_H)
) (
   input wire                  clk_camera,
   input wire                  sys_rst_camera,
   input wire                  wr_req_i,
   input wire [AW-1:0]         wr_addr_i,
   input wire cam_pkg::pixel_t wr_data_i,
   input wire                  rd_req_i,
   input wire [AW-1:0]         rd_addr_i,
   input wire cam_pkg::pixel_t mem_rdata_i,
   output logic                rd_valid_o,
   output cam_pkg::pixel_t     rd_data_o,
   output logic                mem_we_o,
   output logic [AW-1:0]       mem_addr_o,
   output cam_pkg::pixel_t     mem_wdata_o
);

   logic          rd_pend;
   logic [AW-1:0] rd_addr_q;
   logic          rd_serve;
   // read went to the memory last cycle
   logic          rd_issued;

   // camera writes always win the port
   assign rd_serve    = rd_pend & ~wr_req_i;
   assign mem_we_o    = wr_req_i;
   assign mem_addr_o  = wr_req_i ? wr_addr_i : rd_addr_q;
   assign mem_wdata_o = wr_data_i;

   // memory output is registered, so data and valid line up
   assign rd_valid_o  = rd_issued;
   assign rd_data_o   = mem_rdata_i;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         rd_pend   <= 1'b0;
         rd_issued <= 1'b0;
      end else begin
         rd_issued <= rd_serve;
         // only one read in flight, extra pulses are dropped
         if (rd_req_i && !rd_pend) begin
            rd_pend <= 1'b1;
         end else if (rd_serve) begin
            rd_pend <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (rd_req_i && !rd_pend) begin
         rd_addr_q <= rd_addr_i;
      end
   end

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_buffer #(
   parameter int  FRAME_W = 320,
   parameter int  FRAME_H = 180,
   localparam int DEPTH   = FRAME_W * FRAME_H,
   localparam int AW      = $clog2(DEPTH)
) (
   input wire                  clk_camera,
   input wire                  we_i,
   input wire [AW-1:0]         addr_i,
   input wire cam_pkg::pixel_t wdata_i,
   output cam_pkg::pixel_t     rdata_o
);

   cam_pkg::pixel_t mem [DEPTH];

   // single port, read data one cycle after the address
   always_ff @(posedge clk_camera) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];
   end

endmodule

`default_nettype wire

// ==== camera_tracker_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module camera_tracker_top #(
   parameter int  FRAME_W = 320,
   parameter int  FRAME_H = 180,
   localparam int HW      = $clog2(FRAME_W),
   localparam int VW      = $clog2(FRAME_H),
   localparam int AW      = $clog2(FRAME_W * FRAME_H)
) (
   input wire                clk_camera,
   input wire                sys_rst_camera,
   input wire                cam_pclk_i,
   input wire                cam_hs_i,
   input wire                cam_vs_i,
   input wire [7:0]          cam_data_i,
   input var cam_pkg::view_e view_i,
   input wire                rd_req_i,
   input wire [AW-1:0]       rd_addr_i,
   output logic              rd_valid_o,
   output cam_pkg::pixel_t   rd_data_o,
   output logic [HW-1:0]     com_x_o,
   output logic [VW-1:0]     com_y_o,
   output logic              com_valid_o
);

   // camera bus to pixels
   logic            pix_valid;
   cam_pkg::pixel_t pix;
   logic [HW-1:0]   pix_hcount;
   logic [VW-1:0]   pix_vcount;
   // threshold stage
   logic            thr_valid;
   logic            thr_mask;
   cam_pkg::pixel_t thr_pix;
   logic [HW-1:0]   thr_hcount;
   logic [VW-1:0]   thr_vcount;
   logic            has_com;
   // writer to arbiter to memory
   logic            wr_req;
   logic [AW-1:0]   wr_addr;
   cam_pkg::pixel_t wr_data;
   logic            mem_we;
   logic [AW-1:0]   mem_addr;
   cam_pkg::pixel_t mem_wdata;
   cam_pkg::pixel_t mem_rdata;

   pixel_reconstruct #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) pixel_reconstruct_i (
      .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
      .cam_pclk_i(cam_pclk_i), .cam_hs_i(cam_hs_i), .cam_vs_i(cam_vs_i),
      .cam_data_i(cam_data_i), .pix_valid_o(pix_valid), .pix_o(pix),
      .hcount_o(pix_hcount), .vcount_o(pix_vcount)
   );

   pink_threshold #(.HCOUNT_W(HW), .VCOUNT_W(VW)) pink_threshold_i (
      .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
      .pix_valid_i(pix_valid), .pix_i(pix), .hcount_i(pix_hcount), .vcount_i(pix_vcount),
      .thr_valid_o(thr_valid), .mask_o(thr_mask), .pix_o(thr_pix),
      .hcount_o(thr_hcount), .vcount_o(thr_vcount)
   );

   centroid_tracker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) centroid_tracker_i (
      .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
      .thr_valid_i(thr_valid), .mask_i(thr_mask),
      .hcount_i(thr_hcount), .vcount_i(thr_vcount),
      .com_x_o(com_x_o), .com_y_o(com_y_o), .com_valid_o(com_valid_o),
      .has_com_o(has_com)
   );

   frame_writer #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) frame_writer_i (
      .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
      .thr_valid_i(thr_valid), .mask_i(thr_mask), .pix_i(thr_pix),
      .hcount_i(thr_hcount), .vcount_i(thr_vcount),
      .com_x_i(com_x_o), .com_y_i(com_y_o), .has_com_i(has_com), .view_i(view_i),
      .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
   );

   fb_arbiter #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) fb_arbiter_i (
      .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
      .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
      .rd_req_i(rd_req_i), .rd_addr_i(rd_addr_i), .mem_rdata_i(mem_rdata),
      .rd_valid_o(rd_valid_o), .rd_data_o(rd_data_o),
      .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
   );

   frame_buffer #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) frame_buffer_i (
      .clk_camera(clk_camera), .we_i(mem_we), .addr_i(mem_addr),
      .wdata_i(mem_wdata), .rdata_o(mem_rdata)
   );

endmodule

`default_nettype wire

// ==== camera_tracker_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module camera_tracker_assert (
   input wire clk_i,
   input wire rst_i,
   input wire rd_req_i,
   input wire rd_pend_i,
   input wire rd_valid_i,
   input wire com_valid_i
);

   // set by any failing assertion
   bit fail_seen = 1'b0;

   // response only two or three cycles after an accepted read
   a_valid_after_issue : assert property (@(posedge clk_i) disable iff (rst_i)
      rd_valid_i |-> ($past(rd_req_i && !rd_pend_i, 2) || $past(rd_req_i && !rd_pend_i, 3)))
   else begin
      $error("rd_valid_o without an accepted read");
      fail_seen = 1'b1;
   end

   // exactly one of the two slots after an accepted request carries the pulse
   a_read_answered : assert property (@(posedge clk_i) disable iff (rst_i)
      (rd_req_i && !rd_pend_i) |-> ##3 (rd_valid_i != $past(rd_valid_i)))
   else begin
      $error("accepted read did not get exactly one rd_valid_o in time");
      fail_seen = 1'b1;
   end

   a_com_single : assert property (@(posedge clk_i) disable iff (rst_i)
      com_valid_i |=> !com_valid_i)
   else begin
      $error("com_valid_o longer than one cycle");
      fail_seen = 1'b1;
   end

endmodule

// arbiter side, centroid input tied off
bind fb_arbiter camera_tracker_assert arb_check_i (
   .clk_i(clk_camera), .rst_i(sys_rst_camera),
   .rd_req_i(rd_req_i), .rd_pend_i(rd_pend),
   .rd_valid_i(rd_valid_o), .com_valid_i(1'b0)
);

// tracker side, read inputs tied off
bind centroid_tracker camera_tracker_assert com_check_i (
   .clk_i(clk_camera), .rst_i(sys_rst_camera),
   .rd_req_i(1'b0), .rd_pend_i(1'b0),
   .rd_valid_i(1'b0), .com_valid_i(com_valid_o)
);

`default_nettype wire

// ==== tb_camera_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_camera_tracker;

   localparam int FRAME_W   = 8;
   localparam int FRAME_H   = 4;
   localparam int NPIX      = FRAME_W * FRAME_H;
   localparam int HW        = $clog2(FRAME_W);
   localparam int VW        = $clog2(FRAME_H);
   localparam int AW        = $clog2(NPIX);
   localparam int DRIVE_DLY = 2;
   // camera bus clocks per frame, 4 clocks per pixel plus line gaps
   localparam int FRAME_CYCLES = 6 + FRAME_H * (4 + FRAME_W * 4);
   // full readback, at most 6 clocks per read
   localparam int READ_CYCLES  = NPIX * 6;
   // two quotients of well under 16 steps each
   localparam int DIV_WAIT     = 60;
   localparam int N_FRAMES     = 5;
   localparam int TIMEOUT_CYCLES =
      2 * (N_FRAMES * (FRAME_CYCLES + READ_CYCLES + DIV_WAIT) + 100);
   // frame fill kinds
   localparam int FILL_RANDOM  = 0;
   localparam int FILL_NO_PINK = 1;
   localparam int FILL_BLOCK   = 2;

   logic            clk_camera = 1'b0;
   logic            sys_rst_camera;
   logic            cam_pclk;
   logic            cam_hs;
   logic            cam_vs;
   logic [7:0]      cam_data;
   cam_pkg::view_e  view_sel;
   logic            rd_req;
   logic [AW-1:0]   rd_addr;
   logic            rd_valid;
   cam_pkg::pixel_t rd_data;
   logic [HW-1:0]   com_x;
   logic [VW-1:0]   com_y;
   logic            com_valid;

   // stimulus and reference model state
   logic [31:0]     rng_state = 32'd79051;
   cam_pkg::pixel_t frame_pix [NPIX];
   cam_pkg::pixel_t exp_mem [NPIX];
   bit              mdl_has_com;
   int              mdl_com_x;
   int              mdl_com_y;
   int              com_pulses = 0;
   int              rd_pulses = 0;
   int              reads_sent = 0;
   int              cycle_count = 0;

   always #10 clk_camera = ~clk_camera;

   camera_tracker_top #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) camera_tracker_top_i (
      .clk_camera(clk_camera), .sys_rst_camera(sys_rst_camera),
      .cam_pclk_i(cam_pclk), .cam_hs_i(cam_hs), .cam_vs_i(cam_vs), .cam_data_i(cam_data),
      .view_i(view_sel), .rd_req_i(rd_req), .rd_addr_i(rd_addr),
      .rd_valid_o(rd_valid), .rd_data_o(rd_data),
      .com_x_o(com_x), .com_y_o(com_y), .com_valid_o(com_valid)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         report_failure($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, exp, act));
      end
   endtask

   // pulse counters, cycle limit and bound checker flags
   always @(posedge clk_camera) begin
      cycle_count++;
      if (com_valid) begin
         com_pulses++;
      end
      if (rd_valid) begin
         rd_pulses++;
      end
      if (cycle_count >= TIMEOUT_CYCLES) begin
         report_failure("timeout, the run did not finish within the cycle limit");
      end
      if (camera_tracker_top_i.fb_arbiter_i.arb_check_i.fail_seen ||
          camera_tracker_top_i.centroid_tracker_i.com_check_i.fail_seen) begin
         report_failure("a bound assertion on the arbiter or centroid tracker failed");
      end
   end

   // xorshift32
   function automatic logic [31:0] next_random();
      logic [31:0] s;
      s = rng_state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      rng_state = s;
      return s;
   endfunction

   // cr = 128 + floor((112 r - 94 g - 18 b) / 256) on 8 bit channels
   function automatic bit is_pink(input cam_pkg::pixel_t p);
      int r;
      int g;
      int b;
      int num;
      int q;
      int cr;
      r   = int'(p[15:11]) * 8;
      g   = int'(p[10:5]) * 4;
      b   = int'(p[4:0]) * 8;
      num = 112 * r - 94 * g - 18 * b;
      // integer divide truncates, so round negatives down by hand
      if (num >= 0) begin
         q = num / 256;
      end else begin
         q = -((-num + 255) / 256);
      end
      cr = 128 + q;
      return (cr >= int'(cam_pkg::CR_LOW)) && (cr <= int'(cam_pkg::CR_HIGH));
   endfunction

   function automatic cam_pkg::pixel_t expected_pixel(input int col, input int row,
                                                      input cam_pkg::pixel_t p,
                                                      input cam_pkg::view_e view);
      if (mdl_has_com && (row == mdl_com_y || col == mdl_com_x)) begin
         return 16'hFFFF;
      end
      if (view == cam_pkg::VIEW_MASK) begin
         return is_pink(p) ? 16'hFFFF : 16'h0000;
      end
      return p;
   endfunction

   function automatic cam_pkg::pixel_t pick_pixel(input bit want_pink);
      logic [31:0] word;
      word = next_random();
      while (is_pink(word[15:0]) != want_pink) begin
         word = next_random();
      end
      return word[15:0];
   endfunction

   task automatic next_cycle(input int n);
      repeat (n) begin
         @(posedge clk_camera);
      end
      #DRIVE_DLY;
   endtask

   // pclk low one clock then high one clock, data held across both
   task automatic send_byte(input logic [7:0] b);
      cam_data = b;
      cam_pclk = 1'b0;
      next_cycle(1);
      cam_pclk = 1'b1;
      next_cycle(1);
   endtask

   task automatic send_frame();
      cam_vs = 1'b1;
      next_cycle(3);
      cam_vs = 1'b0;
      next_cycle(3);
      for (int r = 0; r < FRAME_H; r++) begin
         cam_hs = 1'b1;
         next_cycle(1);
         for (int c = 0; c < FRAME_W; c++) begin
            // high byte first
            send_byte(frame_pix[r * FRAME_W + c][15:8]);
            send_byte(frame_pix[r * FRAME_W + c][7:0]);
         end
         cam_hs = 1'b0;
         next_cycle(3);
      end
   endtask

   task automatic fill_frame(input int kind);
      int          col;
      int          row;
      logic [31:0] word;
      for (int a = 0; a < NPIX; a++) begin
         col = a % FRAME_W;
         row = a / FRAME_W;
         if (kind == FILL_RANDOM) begin
            word         = next_random();
            frame_pix[a] = word[15:0];
         end else begin
            // pink block on columns 2 to 5 of rows 1 and 2
            frame_pix[a] = pick_pixel(kind == FILL_BLOCK && col >= 2 && col <= 5 &&
                                      row >= 1 && row <= 2);
         end
      end
   endtask

   task automatic read_pixel(input int addr, output cam_pkg::pixel_t data);
      int waited;
      rd_req  = 1'b1;
      rd_addr = AW'(addr);
      next_cycle(1);
      rd_req = 1'b0;
      reads_sent++;
      waited = 0;
      next_cycle(1);
      while (!rd_valid && waited < 4) begin
         next_cycle(1);
         waited++;
      end
      if (!rd_valid) begin
         report_failure($sformatf("read of address %0d got no rd_valid_o", addr));
      end
      data = rd_data;
   endtask

   // host reads racing the camera writes, data not checked here
   task automatic stream_reads(input int n);
      cam_pkg::pixel_t dummy;
      logic [31:0]     word;
      for (int i = 0; i < n; i++) begin
         word = next_random();
         read_pixel(int'(word[7:0]) % NPIX, dummy);
         next_cycle(1 + int'(word[9:8]));
      end
   endtask

   task automatic wait_for_com(input string name, input int pulses_before);
      int waited;
      waited = 0;
      while (!com_valid && com_pulses == pulses_before && waited < DIV_WAIT) begin
         next_cycle(1);
         waited++;
      end
      if (!com_valid && com_pulses == pulses_before) begin
         report_failure($sformatf("%s gave no com_valid_o after its frame", name));
      end
   endtask

   task automatic run_frame(input string name, input cam_pkg::view_e view,
                            input bit with_reads);
      int              n_pink;
      int              sum_x;
      int              sum_y;
      int              pulses_before;
      cam_pkg::pixel_t got;
      n_pink = 0;
      sum_x  = 0;
      sum_y  = 0;
      // overlay uses the centre known before this frame
      for (int a = 0; a < NPIX; a++) begin
         exp_mem[a] = expected_pixel(a % FRAME_W, a / FRAME_W, frame_pix[a], view);
         if (is_pink(frame_pix[a])) begin
            n_pink++;
            sum_x += a % FRAME_W;
            sum_y += a / FRAME_W;
         end
      end
      view_sel      = view;
      pulses_before = com_pulses;
      if (with_reads) begin
         fork
            send_frame();
            stream_reads(12);
         join
      end else begin
         send_frame();
      end
      if (n_pink != 0) begin
         wait_for_com(name, pulses_before);
         mdl_has_com = 1'b1;
         mdl_com_x   = sum_x / n_pink;
         mdl_com_y   = sum_y / n_pink;
         check_value({name, " com_x"}, mdl_com_x, com_x);
         check_value({name, " com_y"}, mdl_com_y, com_y);
      end else begin
         next_cycle(DIV_WAIT);
         check_value({name, " com pulses"}, pulses_before, com_pulses);
         if (mdl_has_com) begin
            check_value({name, " held com_x"}, mdl_com_x, com_x);
            check_value({name, " held com_y"}, mdl_com_y, com_y);
         end
      end
      for (int a = 0; a < NPIX; a++) begin
         read_pixel(a, got);
         check_value($sformatf("%s addr %0d", name, a), exp_mem[a], got);
      end
   endtask

   initial begin
      sys_rst_camera = 1'b1;
      cam_pclk       = 1'b0;
      cam_hs         = 1'b0;
      cam_vs         = 1'b0;
      cam_data       = '0;
      view_sel       = cam_pkg::VIEW_CAMERA;
      rd_req         = 1'b0;
      rd_addr        = '0;
      mdl_has_com    = 1'b0;
      mdl_com_x      = 0;
      mdl_com_y      = 0;
      repeat (4) @(posedge clk_camera);
      #DRIVE_DLY;
      sys_rst_camera = 1'b0;
      // nothing should pulse before the first frame
      for (int i = 0; i < 20; i++) begin
         next_cycle(1);
         check_value("idle rd_valid_o", 0, rd_valid);
         check_value("idle com_valid_o", 0, com_valid);
      end
      fill_frame(FILL_RANDOM);
      run_frame("random camera frame", cam_pkg::VIEW_CAMERA, 1'b0);
      fill_frame(FILL_BLOCK);
      run_frame("pink block frame", cam_pkg::VIEW_CAMERA, 1'b0);
      // same pixels again so the centre stays at the block
      run_frame("mask view frame", cam_pkg::VIEW_MASK, 1'b0);
      fill_frame(FILL_NO_PINK);
      run_frame("no pink frame", cam_pkg::VIEW_CAMERA, 1'b0);
      fill_frame(FILL_RANDOM);
      run_frame("streaming reads frame", cam_pkg::VIEW_CAMERA, 1'b1);
      // the last read is judged three clocks after its request
      next_cycle(3);
      check_value("read pulse count", reads_sent, rd_pulses);
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
cam_pkg.sv
pixel_reconstruct.sv
pink_threshold.sv
centroid_tracker.sv
frame_writer.sv
fb_arbiter.sv
frame_buffer.sv
camera_tracker_top.sv
camera_tracker_assert.sv
tb_camera_tracker.sv

// ==== Bender.yml ====
package:
  name: camera_tracker

sources:
  - cam_pkg.sv
  - pixel_reconstruct.sv
  - pink_threshold.sv
  - centroid_tracker.sv
  - frame_writer.sv
  - fb_arbiter.sv
  - frame_buffer.sv
  - camera_tracker_top.sv
  - target: simulation
    files:
      - camera_tracker_assert.sv
      - tb_camera_tracker.sv
